//--- design/rgmii_pkg.sv
// ----------------------------------------------------------
// Shared definitions for the RGMII port adapter
// Link speed and divider FSM enums
// Lane, byte and divider counter vector types
// Transmit clock divider counts, reset sync length
// Transmit clock phase selection
// ----------------------------------------------------------

package rgmii_pkg;

    // Link speed as driven by the MAC, value 3 runs as 1000
    typedef enum logic [1:0] {
        SPEED_10   = 2'd0,
        SPEED_100  = 2'd1,
        SPEED_1000 = 2'd2
    } speed_t;

    // Transmit clock divider states
    typedef enum logic [1:0] {
        GIGA,
        COUNT_LOW,
        COUNT_HIGH
    } txclk_state_t;

    typedef logic [3:0] nibble_t;
    typedef logic [7:0] byte_t;
    typedef logic [5:0] div_count_t;

    // 100M, five clk cycles per transmit clock
    localparam div_count_t DIV100_RISE = 6'd2;
    localparam div_count_t DIV100_END  = 6'd4;

    // 10M, fifty clk cycles per transmit clock
    localparam div_count_t DIV10_RISE = 6'd24;
    localparam div_count_t DIV10_END  = 6'd49;

    // Flops per reset synchronizer
    localparam int RST_SYNC_STAGES = 4;

    // Clock DDR register runs on clk90 for a centred transmit clock
    localparam bit USE_CLK90 = 1'b1;

endpackage

//--- design/tx_clk_phase_if.sv
// ----------------------------------------------------------
// Transmit clock phase bundle
// Half-cycle clock levels and edge strobes from the
// divider to the transmit encoder
// ----------------------------------------------------------

`timescale 1ns/1ps

interface tx_clk_phase_if;

    // Level of tx_clk in the high and low halves of clk
    logic clk_lvl1;
    logic clk_lvl2;

    // One-cycle strobes on tx_clk edges
    logic rise;
    logic fall;

    modport source (output clk_lvl1, output clk_lvl2, output rise, output fall);

    modport sink (input clk_lvl1, input clk_lvl2, input rise, input fall);

endinterface

//--- design/ddr_in.sv
// ----------------------------------------------------------
// Generic input DDR capture
// Samples on both edges of the input clock and presents
// the rising/falling pair together in the rising domain
// ----------------------------------------------------------

`timescale 1ns/1ps

module ddr_in #(
    parameter int WIDTH = 1
) (
    input  logic             in_clk,
    input  logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q1,
    output logic [WIDTH-1:0] q2
);

    // Raw edge samples
    logic [WIDTH-1:0] d_rise;
    logic [WIDTH-1:0] d_fall;

    // Rising edge sample
    always_ff @(posedge in_clk) begin
        d_rise <= d;
    end

    // Falling edge sample, half a cycle after d_rise
    always_ff @(negedge in_clk) begin
        d_fall <= d;
    end

    // Realign the pair on the following rising edge
    // q1 holds the earlier rising sample, q2 the falling one after it
    always_ff @(posedge in_clk) begin
        q1 <= d_rise;
        q2 <= d_fall;
    end

endmodule

//--- design/ddr_out.sv
// ----------------------------------------------------------
// Generic output DDR register
// First word out in the high half of clk,
// second word out in the low half
// ----------------------------------------------------------

`timescale 1ns/1ps

module ddr_out #(
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic [WIDTH-1:0] d1,
    input  logic [WIDTH-1:0] d2,
    output logic [WIDTH-1:0] q
);

    // Both words captured together
    logic [WIDTH-1:0] d1_reg;
    logic [WIDTH-1:0] d2_reg;

    always_ff @(posedge clk) begin
        d1_reg <= d1;
        d2_reg <= d2;
    end

    // Clock phase picks the word
    // high half follows the capture edge directly
    always_comb begin
        if (clk) begin
            q = d1_reg;
        end else begin
            q = d2_reg;
        end
    end

endmodule

//--- design/rgmii_tx_clk_gen.sv
// ----------------------------------------------------------
// Speed-dependent transmit clock divider
// Static levels at 1000, divide by 5 at 100 and by 50
// at 10, with rise/fall strobes for the encoder and
// the MAC clock enable
// ----------------------------------------------------------

`timescale 1ns/1ps

module rgmii_tx_clk_gen
    import rgmii_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  speed_t                speed,
    tx_clk_phase_if.source        phase
);

    txclk_state_t state;
    div_count_t   count;

    // Speed seen last cycle, a change restarts the count
    speed_t speed_q;
    speed_t spd;

    div_count_t rise_cnt;
    div_count_t end_cnt;

    // Fold the unused code 3 into 1000
    always_comb begin
        case (speed)
            SPEED_10:  spd = SPEED_10;
            SPEED_100: spd = SPEED_100;
            default:   spd = SPEED_1000;
        endcase
    end

    // Divider end points for the slow speeds
    assign rise_cnt = (spd == SPEED_10) ? DIV10_RISE : DIV100_RISE;
    assign end_cnt  = (spd == SPEED_10) ? DIV10_END : DIV100_END;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= GIGA;
            count          <= '0;
            speed_q        <= SPEED_1000;
            phase.clk_lvl1 <= 1'b1;
            phase.clk_lvl2 <= 1'b0;
            phase.rise     <= 1'b1;
            phase.fall     <= 1'b1;
        end else begin
            speed_q <= spd;
            // First half repeats last second half unless overridden
            phase.clk_lvl1 <= phase.clk_lvl2;
            phase.rise     <= 1'b0;
            phase.fall     <= 1'b0;

            if (spd == SPEED_1000) begin
                // Clock follows clk, both edges every cycle
                state          <= GIGA;
                count          <= '0;
                phase.clk_lvl1 <= 1'b1;
                phase.clk_lvl2 <= 1'b0;
                phase.rise     <= 1'b1;
                phase.fall     <= 1'b1;
            end else if (spd != speed_q) begin
                // New slow speed, start a fresh low phase
                state          <= COUNT_LOW;
                count          <= '0;
                phase.clk_lvl1 <= 1'b0;
                phase.clk_lvl2 <= 1'b0;
            end else begin
                count <= count + div_count_t'(1);
                case (state)
                    COUNT_LOW: begin
                        if (count == rise_cnt) begin
                            state          <= COUNT_HIGH;
                            phase.clk_lvl1 <= 1'b1;
                            phase.clk_lvl2 <= 1'b1;
                            phase.rise     <= 1'b1;
                        end
                    end
                    COUNT_HIGH: begin
                        if (count >= end_cnt) begin
                            state          <= COUNT_LOW;
                            count          <= '0;
                            phase.clk_lvl2 <= 1'b0;
                            phase.fall     <= 1'b1;
                            // At 100 the first half stays high for a 2.5 cycle pulse
                            if (spd == SPEED_10) begin
                                phase.clk_lvl1 <= 1'b0;
                            end
                        end
                    end
                    default: begin
                        state <= COUNT_LOW;
                        count <= '0;
                    end
                endcase
            end
        end
    end

    // Edges only coincide when the clock runs at clk rate
    a_single_edge: assert property (@(posedge clk) disable iff (rst)
        (state != GIGA) |-> !(phase.rise && phase.fall));

endmodule

//--- design/rgmii_phy_if.sv
// ----------------------------------------------------------
// GMII/RGMII conversion
// Receive decode of DDR nibble pairs into GMII
// Transmit encode of GMII into DDR words for each speed
// Reset synchronizers for the receive and transmit domains
// ----------------------------------------------------------

`timescale 1ns/1ps

module rgmii_phy_if
    import rgmii_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  speed_t         speed,
    tx_clk_phase_if.sink   phase,

    // Receive side, pairs from the input DDR
    input  logic           rx_clk,
    input  logic [4:0]     rx_q1,
    input  logic [4:0]     rx_q2,

    // Transmit side, words to the output DDR
    output logic [4:0]     tx_d1,
    output logic [4:0]     tx_d2,

    // GMII to MAC
    output byte_t          mac_gmii_rxd,
    output logic           mac_gmii_rx_dv,
    output logic           mac_gmii_rx_er,
    output logic           mac_gmii_rx_rst,
    input  byte_t          mac_gmii_txd,
    input  logic           mac_gmii_tx_en,
    input  logic           mac_gmii_tx_er,
    output logic           mac_gmii_tx_rst,
    output logic           mac_gmii_tx_clk_en
);

    // Word layout is {nibble, ctl}
    nibble_t txd_1;
    nibble_t txd_2;
    logic    tx_ctl_1;
    logic    tx_ctl_2;
    logic    tx_err_ctl;

    // Reset pipes per domain, output taken from bit 0
    logic [RST_SYNC_STAGES-1:0] tx_rst_pipe;
    logic [RST_SYNC_STAGES-1:0] rx_rst_pipe;

    // Receive decode
    // Falling nibble carries the upper half of the byte
    assign mac_gmii_rxd   = {rx_q2[4:1], rx_q1[4:1]};
    assign mac_gmii_rx_dv = rx_q1[0];
    // Second ctl bit is dv xor er on the wire
    assign mac_gmii_rx_er = rx_q1[0] ^ rx_q2[0];

    // Second-half control value carries en xor er
    assign tx_err_ctl = mac_gmii_tx_en ^ mac_gmii_tx_er;

    // Transmit encode
    always_comb begin
        case (speed)
            SPEED_10, SPEED_100: begin
                // Same low nibble on both halves
                txd_1 = mac_gmii_txd[3:0];
                txd_2 = mac_gmii_txd[3:0];
                // Control follows the divided clock level
                if (phase.clk_lvl2) begin
                    tx_ctl_1 = mac_gmii_tx_en;
                    tx_ctl_2 = mac_gmii_tx_en;
                end else begin
                    tx_ctl_1 = tx_err_ctl;
                    tx_ctl_2 = tx_err_ctl;
                end
            end
            default: begin
                // Low nibble first, then high nibble
                txd_1    = mac_gmii_txd[3:0];
                txd_2    = mac_gmii_txd[7:4];
                tx_ctl_1 = mac_gmii_tx_en;
                tx_ctl_2 = tx_err_ctl;
            end
        endcase
    end

    assign tx_d1 = {txd_1, tx_ctl_1};
    assign tx_d2 = {txd_2, tx_ctl_2};

    // MAC steps to the next nibble on each tx_clk fall
    assign mac_gmii_tx_clk_en = phase.fall;

    // Reset synchronizers
    // async assert, release after RST_SYNC_STAGES edges of own clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_rst_pipe <= '1;
        end else begin
            tx_rst_pipe <= {1'b0, tx_rst_pipe[RST_SYNC_STAGES-1:1]};
        end
    end

    always_ff @(posedge rx_clk or posedge rst) begin
        if (rst) begin
            rx_rst_pipe <= '1;
        end else begin
            rx_rst_pipe <= {1'b0, rx_rst_pipe[RST_SYNC_STAGES-1:1]};
        end
    end

    assign mac_gmii_tx_rst = tx_rst_pipe[0];
    assign mac_gmii_rx_rst = rx_rst_pipe[0];

    // Divider must hand back a constant enable once at gigabit
    a_giga_clk_en: assert property (@(posedge clk) disable iff (rst)
        (speed inside {SPEED_1000, speed_t'(2'd3)} &&
         $past(speed) inside {SPEED_1000, speed_t'(2'd3)}) |-> mac_gmii_tx_clk_en);

endmodule

//--- design/rgmii_port.sv
// ----------------------------------------------------------
// Tri-speed RGMII port, top level
// Input and output DDR registers, transmit clock
// divider and GMII/RGMII conversion
// ----------------------------------------------------------

`timescale 1ns/1ps

module rgmii_port
    import rgmii_pkg::*;
(
    input  logic       clk,
    input  logic       clk90,
    input  logic       rst,
    input  logic [1:0] speed,

    // GMII to MAC
    output logic       mac_gmii_rx_clk,
    output logic       mac_gmii_rx_rst,
    output byte_t      mac_gmii_rxd,
    output logic       mac_gmii_rx_dv,
    output logic       mac_gmii_rx_er,
    output logic       mac_gmii_tx_clk,
    output logic       mac_gmii_tx_rst,
    output logic       mac_gmii_tx_clk_en,
    input  byte_t      mac_gmii_txd,
    input  logic       mac_gmii_tx_en,
    input  logic       mac_gmii_tx_er,

    // RGMII to PHY
    input  logic       phy_rgmii_rx_clk,
    input  nibble_t    phy_rgmii_rxd,
    input  logic       phy_rgmii_rx_ctl,
    output logic       phy_rgmii_tx_clk,
    output nibble_t    phy_rgmii_txd,
    output logic       phy_rgmii_tx_ctl
);

    speed_t     speed_sel;
    logic [4:0] rx_q1;
    logic [4:0] rx_q2;
    logic [4:0] tx_d1;
    logic [4:0] tx_d2;
    logic       tx_ddr_clk;

    tx_clk_phase_if phase ();

    // Raw code 3 passes through, downstream treats it as 1000
    assign speed_sel = speed_t'(speed);

    assign mac_gmii_rx_clk = phy_rgmii_rx_clk;
    assign mac_gmii_tx_clk = clk;

    // Quarter-cycle shift centres tx_clk on the data
    assign tx_ddr_clk = USE_CLK90 ? clk90 : clk;

    rgmii_tx_clk_gen tx_clk_gen_inst (
        .clk   (clk),
        .rst   (rst),
        .speed (speed_sel),
        .phase (phase.source)
    );

    // Receive pins, {rxd, ctl} per edge
    ddr_in #(.WIDTH(5)) rx_ddr_inst (
        .in_clk (phy_rgmii_rx_clk),
        .d      ({phy_rgmii_rxd, phy_rgmii_rx_ctl}),
        .q1     (rx_q1),
        .q2     (rx_q2)
    );

    rgmii_phy_if phy_if_inst (
        .clk                (clk),
        .rst                (rst),
        .speed              (speed_sel),
        .phase              (phase.sink),
        .rx_clk             (phy_rgmii_rx_clk),
        .rx_q1              (rx_q1),
        .rx_q2              (rx_q2),
        .tx_d1              (tx_d1),
        .tx_d2              (tx_d2),
        .mac_gmii_rxd       (mac_gmii_rxd),
        .mac_gmii_rx_dv     (mac_gmii_rx_dv),
        .mac_gmii_rx_er     (mac_gmii_rx_er),
        .mac_gmii_rx_rst    (mac_gmii_rx_rst),
        .mac_gmii_txd       (mac_gmii_txd),
        .mac_gmii_tx_en     (mac_gmii_tx_en),
        .mac_gmii_tx_er     (mac_gmii_tx_er),
        .mac_gmii_tx_rst    (mac_gmii_tx_rst),
        .mac_gmii_tx_clk_en (mac_gmii_tx_clk_en)
    );

    // Transmit data and control
    ddr_out #(.WIDTH(5)) tx_data_ddr_inst (
        .clk (clk),
        .d1  (tx_d1),
        .d2  (tx_d2),
        .q   ({phy_rgmii_txd, phy_rgmii_tx_ctl})
    );

    // Transmit clock from the divider levels
    ddr_out #(.WIDTH(1)) tx_clk_ddr_inst (
        .clk (tx_ddr_clk),
        .d1  (phase.clk_lvl1),
        .d2  (phase.clk_lvl2),
        .q   (phy_rgmii_tx_clk)
    );

endmodule

//--- tests/tb_clock_gen.sv
// ----------------------------------------------------------
// Testbench clock source
// System clock with a 100 ns period, a copy delayed by a
// quarter period, and the PHY receive clock with its own
// 40 ns offset
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic clk90,
    output logic rx_clk
);

    localparam time HALF_PERIOD = 50ns;

    // System clock, first rise at 50 ns
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Quarter period behind clk
    initial begin
        clk90 = 1'b0;
        #25ns;
        forever #(HALF_PERIOD) clk90 = ~clk90;
    end

    // PHY receive clock, not related to clk
    initial begin
        rx_clk = 1'b0;
        #40ns;
        forever begin
            rx_clk = ~rx_clk;
            #(HALF_PERIOD);
        end
    end

endmodule

//--- tests/tb_rgmii_port.sv
// ----------------------------------------------------------
// Testbench for the tri-speed RGMII port
// Reset release checks for both domains
// Random receive nibbles against a decode model queue
// Transmit checks at 1000, 100 and 10 with speed changes
// Watchdog on the total run length
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_rgmii_port
    import rgmii_pkg::*;
();

    localparam int CLK_PERIOD_NS = 100;
    localparam int RESET_CYCLES  = 2;
    localparam int N_RX          = 400;
    localparam int N_GIGA        = 80;
    localparam int N_100         = 100;
    localparam int N_10          = 300;
    localparam int N_GIGA2       = 40;
    localparam int N_1002        = 60;
    // Each phase also waits one new period plus a little
    localparam int TX_CYCLES = N_GIGA + N_100 + N_10 + N_GIGA2 + N_1002 + 3 + 7 + 52 + 3 + 7;
    localparam int MARGIN_CYCLES = 200;
    localparam int TIMEOUT_NS =
        (RESET_CYCLES + 10 + N_RX + TX_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS;

    // Error categories
    localparam int CAT_RST = 0;
    localparam int CAT_RX  = 1;
    localparam int CAT_TX  = 2;

    logic       clk;
    logic       clk90;
    logic       rx_clk;
    logic       rst;
    logic [1:0] speed;

    logic    mac_gmii_rx_clk;
    logic    mac_gmii_rx_rst;
    byte_t   mac_gmii_rxd;
    logic    mac_gmii_rx_dv;
    logic    mac_gmii_rx_er;
    logic    mac_gmii_tx_clk;
    logic    mac_gmii_tx_rst;
    logic    mac_gmii_tx_clk_en;
    byte_t   mac_gmii_txd;
    logic    mac_gmii_tx_en;
    logic    mac_gmii_tx_er;
    nibble_t phy_rgmii_rxd;
    logic    phy_rgmii_rx_ctl;
    logic    phy_rgmii_tx_clk;
    nibble_t phy_rgmii_txd;
    logic    phy_rgmii_tx_ctl;

    int errs [3];

    // Expected {rxd, dv, er} per captured pair
    logic [9:0] rx_expect_q [$];

    tb_clock_gen clock_gen_inst (
        .clk    (clk),
        .clk90  (clk90),
        .rx_clk (rx_clk)
    );

    rgmii_port rgmii_port_inst (
        .clk                (clk),
        .clk90              (clk90),
        .rst                (rst),
        .speed              (speed),
        .mac_gmii_rx_clk    (mac_gmii_rx_clk),
        .mac_gmii_rx_rst    (mac_gmii_rx_rst),
        .mac_gmii_rxd       (mac_gmii_rxd),
        .mac_gmii_rx_dv     (mac_gmii_rx_dv),
        .mac_gmii_rx_er     (mac_gmii_rx_er),
        .mac_gmii_tx_clk    (mac_gmii_tx_clk),
        .mac_gmii_tx_rst    (mac_gmii_tx_rst),
        .mac_gmii_tx_clk_en (mac_gmii_tx_clk_en),
        .mac_gmii_txd       (mac_gmii_txd),
        .mac_gmii_tx_en     (mac_gmii_tx_en),
        .mac_gmii_tx_er     (mac_gmii_tx_er),
        .phy_rgmii_rx_clk   (rx_clk),
        .phy_rgmii_rxd      (phy_rgmii_rxd),
        .phy_rgmii_rx_ctl   (phy_rgmii_rx_ctl),
        .phy_rgmii_tx_clk   (phy_rgmii_tx_clk),
        .phy_rgmii_txd      (phy_rgmii_txd),
        .phy_rgmii_tx_ctl   (phy_rgmii_tx_ctl)
    );

    // Numerical Recipes LCG step
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // GMII view of one DDR pair, words are {nibble, ctl}
    // Falling nibble is the high half, er is the xor of the ctl bits
    function automatic logic [9:0] decode_pair(input logic [4:0] rise_w, input logic [4:0] fall_w);
        return {fall_w[4:1], rise_w[4:1], rise_w[0], rise_w[0] ^ fall_w[0]};
    endfunction

    task automatic compare(input int cat, input string test, input logic [15:0] expv,
                           input logic [15:0] actv);
        assert (actv === expv) else begin
            errs[cat]++;
            $display("mismatch %s expected %h actual %h at %0t", test, expv, actv, $time);
        end
    endtask

    task automatic require(input int cat, input logic cond, input string what);
        assert (cond) else begin
            errs[cat]++;
            $display("%s at %0t", what, $time);
        end
    endtask

    // Tx reset must hold for 3 clk edges and drop on the 4th
    task automatic check_tx_reset_release();
        for (int i = 1; i <= RST_SYNC_STAGES; i++) begin
            @(posedge clk);
            #1;
            compare(CAT_RST, "tx_rst_release", 16'(i < RST_SYNC_STAGES), 16'(mac_gmii_tx_rst));
        end
    endtask

    task automatic check_rx_reset_release();
        for (int i = 1; i <= RST_SYNC_STAGES; i++) begin
            @(posedge rx_clk);
            #1;
            compare(CAT_RST, "rx_rst_release", 16'(i < RST_SYNC_STAGES), 16'(mac_gmii_rx_rst));
        end
    endtask

    // Rise word goes in before the rising edge, fall word after it
    // Decoded pair shows on the GMII side one rx clock later
    task automatic run_rx_test();
        logic [31:0] seed;
        logic [4:0]  rise_w;
        logic [4:0]  fall_w;
        logic [9:0]  expv;
        seed = 32'he4c4;
        for (int n = 0; n < N_RX; n++) begin
            @(negedge rx_clk);
            #5;
            compare(CAT_RX, "rx_clk_forward_low", 16'd0, 16'(mac_gmii_rx_clk));
            seed = lcg_next(seed);
            rise_w = seed[20:16];
            {phy_rgmii_rxd, phy_rgmii_rx_ctl} = rise_w;
            @(posedge rx_clk);
            #5;
            compare(CAT_RX, "rx_clk_forward_high", 16'd1, 16'(mac_gmii_rx_clk));
            if (rx_expect_q.size() > 0) begin
                expv = rx_expect_q.pop_front();
                compare(CAT_RX, "rx_rxd", 16'(expv[9:2]), 16'(mac_gmii_rxd));
                compare(CAT_RX, "rx_dv", 16'(expv[1]), 16'(mac_gmii_rx_dv));
                compare(CAT_RX, "rx_er", 16'(expv[0]), 16'(mac_gmii_rx_er));
            end
            seed = lcg_next(seed);
            fall_w = seed[24:20];
            {phy_rgmii_rxd, phy_rgmii_rx_ctl} = fall_w;
            rx_expect_q.push_back(decode_pair(rise_w, fall_w));
        end
    endtask

    // One speed phase: switch, let one new period pass, then check
    // Samples at P+15 (tx_clk low-half level), P+25 and P+75
    task automatic run_tx_phase(input logic [1:0] spd, input int cycles, inout logic [31:0] seed);
        int         period;
        bit         giga;
        bit         have_prev;
        logic [7:0] p_txd;
        logic       p_en;
        logic       p_er;
        logic       clk_s;
        logic       clk_prev_s;
        logic       exp_ctl;
        int         last_ce;
        int         last_rise;
        int         n_ce;
        int         n_rise;
        giga = (spd == 2'd2) || (spd == 2'd3);
        period = giga ? 1 : ((spd == 2'd1) ? 5 : 50);
        @(posedge clk);
        #5;
        speed = spd;
        repeat (period + 2) @(posedge clk);
        have_prev = 0;
        clk_prev_s = 1'b0;
        exp_ctl = 1'b0;
        last_ce = -1;
        last_rise = -1;
        n_ce = 0;
        n_rise = 0;
        p_txd = '0;
        p_en = 1'b0;
        p_er = 1'b0;
        for (int k = 0; k < cycles; k++) begin
            @(posedge clk);
            #5;
            seed = lcg_next(seed);
            mac_gmii_txd = seed[23:16];
            mac_gmii_tx_en = seed[24];
            mac_gmii_tx_er = seed[27];
            #10;
            clk_s = phy_rgmii_tx_clk;
            // MAC transmit clock is clk, high in this half
            compare(CAT_TX, "tx_clk_forward_high", 16'd1, 16'(mac_gmii_tx_clk));
            if (giga) begin
                require(CAT_TX, mac_gmii_tx_clk_en === 1'b1,
                        "transmit clock enable dropped at 1000");
            end else begin
                // Data and control captured last edge
                if (have_prev) begin
                    exp_ctl = clk_s ? p_en : (p_en ^ p_er);
                    compare(CAT_TX, "slow_txd_first", 16'(p_txd[3:0]), 16'(phy_rgmii_txd));
                    compare(CAT_TX, "slow_ctl_first", 16'(exp_ctl), 16'(phy_rgmii_tx_ctl));
                end
                if (mac_gmii_tx_clk_en) begin
                    if (last_ce >= 0) begin
                        compare(CAT_TX, "clk_en_spacing", 16'(period), 16'(k - last_ce));
                    end
                    last_ce = k;
                    n_ce++;
                end
                if (clk_s && !clk_prev_s) begin
                    if (last_rise >= 0) begin
                        compare(CAT_TX, "tx_clk_rise_spacing", 16'(period), 16'(k - last_rise));
                    end
                    last_rise = k;
                    n_rise++;
                end
                clk_prev_s = clk_s;
            end
            #10;
            if (giga && have_prev) begin
                compare(CAT_TX, "giga_txd_high_half", 16'(p_txd[3:0]), 16'(phy_rgmii_txd));
                compare(CAT_TX, "giga_ctl_high_half", 16'(p_en), 16'(phy_rgmii_tx_ctl));
                // clk90 high here, tx_clk follows clk at full rate
                compare(CAT_TX, "giga_tx_clk_high_half", 16'd1, 16'(phy_rgmii_tx_clk));
            end
            #50;
            compare(CAT_TX, "tx_clk_forward_low", 16'd0, 16'(mac_gmii_tx_clk));
            if (have_prev) begin
                if (giga) begin
                    compare(CAT_TX, "giga_txd_low_half", 16'(p_txd[7:4]), 16'(phy_rgmii_txd));
                    compare(CAT_TX, "giga_ctl_low_half", 16'(p_en ^ p_er),
                            16'(phy_rgmii_tx_ctl));
                    compare(CAT_TX, "giga_tx_clk_low_half", 16'd0, 16'(phy_rgmii_tx_clk));
                end else begin
                    compare(CAT_TX, "slow_txd_second", 16'(p_txd[3:0]), 16'(phy_rgmii_txd));
                    compare(CAT_TX, "slow_ctl_second", 16'(exp_ctl), 16'(phy_rgmii_tx_ctl));
                end
            end
            p_txd = mac_gmii_txd;
            p_en = mac_gmii_tx_en;
            p_er = mac_gmii_tx_er;
            have_prev = 1;
        end
        // Each period must show up, not just be evenly spaced
        if (!giga) begin
            require(CAT_TX, n_ce >= cycles / period - 1,
                    "too few transmit clock enable pulses");
            require(CAT_TX, n_rise >= cycles / period - 1, "too few transmit clock rises");
        end
    endtask

    task automatic run_tx_test();
        logic [31:0] seed;
        seed = lcg_next(32'he4c4);
        run_tx_phase(2'd2, N_GIGA, seed);
        run_tx_phase(2'd1, N_100, seed);
        run_tx_phase(2'd0, N_10, seed);
        run_tx_phase(2'd2, N_GIGA2, seed);
        run_tx_phase(2'd1, N_1002, seed);
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT_NS * 1ns);
        $display("Watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int total;
        rst = 1'b1;
        speed = 2'd2;
        mac_gmii_txd = '0;
        mac_gmii_tx_en = 1'b0;
        mac_gmii_tx_er = 1'b0;
        phy_rgmii_rxd = '0;
        phy_rgmii_rx_ctl = 1'b0;
        errs[0] = 0;
        errs[1] = 0;
        errs[2] = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        // Both domains have seen clock edges under reset by now
        compare(CAT_RST, "tx_rst_before_release", 16'd1, 16'(mac_gmii_tx_rst));
        compare(CAT_RST, "rx_rst_before_release", 16'd1, 16'(mac_gmii_rx_rst));
        rst = 1'b0;
        fork
            check_tx_reset_release();
            check_rx_reset_release();
        join
        fork
            run_rx_test();
            run_tx_test();
        join
        total = errs[CAT_RST] + errs[CAT_RX] + errs[CAT_TX];
        $display("Error counts: reset %0d, receive %0d, transmit %0d, total %0d",
                 errs[CAT_RST], errs[CAT_RX], errs[CAT_TX], total);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- flist.f
design/rgmii_pkg.sv
design/tx_clk_phase_if.sv
design/ddr_in.sv
design/ddr_out.sv
design/rgmii_tx_clk_gen.sv
design/rgmii_phy_if.sv
design/rgmii_port.sv
tests/tb_clock_gen.sv
tests/tb_rgmii_port.sv

//--- Makefile
# Verilator build and run for the RGMII port testbench

VERILATOR ?= verilator
TOP       ?= tb_rgmii_port
RTL_TOP   ?= rgmii_port
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
